/* core_top.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/ifetch.sv
rtl/exec_unit.sv
rtl/regfile.sv
rtl/lsu.sv
rtl/bus_arbiter.sv
rtl/core_top.sv
sim/core_checker.sv
sim/tb_core_top.sv

/* Bender.yml */
package:
  name: core_top

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/ifetch.sv
      - rtl/exec_unit.sv
      - rtl/regfile.sv
      - rtl/lsu.sv
      - rtl/bus_arbiter.sv
      - rtl/core_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/core_checker.sv
      - sim/tb_core_top.sv

/* sim/tb_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module tb_core_top import core_pkg::*; ();

  localparam int MEM_WORDS = 1024;

  logic    clk;
  logic    reset_n;
  wb_req_t wb_o;
  wb_rsp_t wb_i;

  word_t   mem [MEM_WORDS];
  word_t   prog [$];
  word_t   exp_adr [$];
  word_t   exp_dat [$];
  word_t   halt_pc;
  int      halt_seen;
  int      wait_cnt;
  bit      mem_busy;
  int      cycle_count;
  int      cycle_budget;

  core_top dut0 (
    .clk     (clk),
    .reset_n (reset_n),
    .wb_o    (wb_o),
    .wb_i    (wb_i)
  );

  core_checker chk0 (
    .clk     (clk),
    .reset_n (reset_n),
    .wb_o    (wb_o),
    .wb_i    (wb_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Memory model with 0 to 3 wait states per cycle
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!reset_n) begin
      wb_i.ack <= #1 1'b0;
      mem_busy = 1'b0;
    end else if (wb_i.ack) begin
      wb_i.ack <= #1 1'b0;
    end else if (wb_o.cyc && wb_o.stb) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        wait_cnt = $urandom_range(3, 0);
      end
      if (wait_cnt == 0) begin
        mem_busy = 1'b0;
        wb_i.ack <= #1 1'b1;
        if (wb_o.we) begin
          mem[wb_o.adr[11:2]] = wb_o.dat;
        end else begin
          wb_i.dat <= #1 mem[wb_o.adr[11:2]];
        end
      end else begin
        wait_cnt--;
      end
    end
  end

  // Counts fetches of the final self jump
  always @(posedge clk) begin
    if (reset_n && wb_o.cyc && wb_o.stb && !wb_o.we && wb_i.ack &&
        wb_o.adr == halt_pc) begin
      halt_seen++;
    end
  end

  // Watchdog whose budget grows with each program
  initial begin
    cycle_count  = 0;
    cycle_budget = 100;
    while (cycle_count <= cycle_budget) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the core did not reach its final jump after %0d cycles",
             cycle_count);
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic word_t enc_r(logic [6:0] f7, reg_adr_t rs2, reg_adr_t rs1,
                                  logic [2:0] f3, reg_adr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_adr_t rs1, logic [2:0] f3,
                                  reg_adr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_adr_t rs2, reg_adr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(logic [12:0] off, reg_adr_t rs2, reg_adr_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_adr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_adr_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic word_t ref_alu(logic [2:0] f3, logic sub, word_t a, word_t b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic alu_f3_ok(logic [2:0] f3);
    return f3 == 3'b000 || f3 == 3'b010 || f3 == 3'b100 || f3 == 3'b110 ||
           f3 == 3'b111;
  endfunction

  // Runs the image until the jump to itself and collects the stores
  function automatic void core_model();
    word_t      x [32];
    word_t      m [MEM_WORDS];
    word_t      pc;
    word_t      next;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      ea;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic [2:0] f3;
    reg_adr_t   rd;
    m  = mem;
    pc = `CORE_RESET_ADDR;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    for (int steps = 0; steps < 4096; steps++) begin
      ins   = m[pc[11:2]];
      f3    = ins[14:12];
      rd    = ins[11:7];
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      if (ins[6:0] == 7'b1101111 && imm_j == '0) begin
        break;
      end
      next = pc + 4;
      case (ins[6:0])
        7'b0110111: x[rd] = {ins[31:12], 12'b0};
        7'b0010011: if (alu_f3_ok(f3)) x[rd] = ref_alu(f3, 1'b0, a, imm_i);
        7'b0110011: begin
          if (alu_f3_ok(f3) && ins[31:25] == 7'b0) begin
            x[rd] = ref_alu(f3, 1'b0, a, b);
          end else if (f3 == 3'b000 && ins[31:25] == 7'b0100000) begin
            x[rd] = ref_alu(f3, 1'b1, a, b);
          end
        end
        7'b0000011: begin
          ea = a + imm_i;
          if (f3 == 3'b010) x[rd] = m[ea[11:2]];
        end
        7'b0100011: begin
          ea = a + imm_s;
          if (f3 == 3'b010) begin
            m[ea[11:2]] = b;
            exp_adr.push_back(ea);
            exp_dat.push_back(b);
          end
        end
        7'b1100011: begin
          if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) next = pc + imm_b;
        end
        7'b1101111: begin
          x[rd] = pc + 4;
          next  = pc + imm_j;
        end
        default: ;
      endcase
      x[0] = '0;
      pc   = next;
    end
  endfunction

  // --------------------------------------------------
  // Program generation
  // --------------------------------------------------
  task automatic emit_random_alu(input reg_adr_t rd);
    int         kind;
    reg_adr_t   rs1;
    reg_adr_t   rs2;
    logic [2:0] f3;
    kind = $urandom_range(11, 0);
    rs1  = $urandom_range(7, 0);
    rs2  = $urandom_range(7, 0);
    case (kind % 6)
      1:       f3 = 3'b000;
      2:       f3 = 3'b010;
      3:       f3 = 3'b100;
      4:       f3 = 3'b110;
      5:       f3 = 3'b111;
      default: f3 = 3'b000;
    endcase
    if (kind == 0) begin
      prog.push_back(enc_u($urandom, rd));
    end else if (kind < 6) begin
      prog.push_back(enc_i($urandom, rs1, f3, rd, 7'b0010011));
    end else begin
      prog.push_back(enc_r(kind == 6 ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd));
    end
  endtask

  // Random values in x1 to x7
  task automatic emit_reg_init();
    for (int r = 1; r < 8; r++) begin
      prog.push_back(enc_u($urandom, r));
      prog.push_back(enc_i($urandom, r, 3'b000, r, 7'b0010011));
    end
  endtask

  task automatic run_program(input string name);
    @(posedge clk);
    #1 reset_n = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ 32'ha5a5_0000;
    end
    // Data preload in the region at 0x700
    for (int i = 0; i < 16; i++) begin
      mem[448 + i] = $urandom;
    end
    prog.push_back(enc_j('0, 5'd0));
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    halt_pc = (prog.size() - 1) * 4;
    exp_adr.delete();
    exp_dat.delete();
    core_model();
    chk0.start_test(name);
    for (int i = 0; i < exp_adr.size(); i++) begin
      chk0.expect_store(exp_adr[i], exp_dat[i]);
    end
    cycle_budget = cycle_count + 200 * prog.size() + 20;
    halt_seen    = 0;
    repeat (2) @(posedge clk);
    #1 reset_n = 1'b1;
    while (halt_seen < 3) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    chk0.finish_test();
    prog.delete();
  endtask

  initial begin
    void'($urandom(32'h16f6_d8c8));
    reset_n    = 1'b0;
    wb_i       = '0;
    halt_pc    = '1;
    halt_seen  = 0;
    mem_busy   = 1'b0;
    wait_cnt   = 0;

    // ALU and LUI with each result stored
    emit_reg_init();
    prog.push_back(enc_u(20'h80000, 5'd1));
    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog.push_back(enc_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3));
    prog.push_back(enc_s(12'h5fc, 5'd3, 5'd0));
    for (int k = 0; k < 24; k++) begin
      emit_random_alu(5'd1 + k % 7);
      prog.push_back(enc_s(12'h600 + 4 * k, 5'd1 + k % 7, 5'd0));
    end
    run_program("alu");

    // Loads and x0 writes
    for (int i = 0; i < 6; i++) begin
      prog.push_back(enc_i(12'h700 + 4 * i, 5'd0, 3'b010, 5'd1 + i, 7'b0000011));
      prog.push_back(enc_s(12'h600 + 4 * i, 5'd1 + i, 5'd0));
    end
    prog.push_back(enc_i(12'h700, 5'd0, 3'b010, 5'd0, 7'b0000011));
    prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd0, 7'b0010011));
    prog.push_back(enc_s(12'h640, 5'd0, 5'd0));
    run_program("loads");

    // Branches, JAL link and a short loop
    prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
    prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog.push_back(enc_i(12'd7, 5'd0, 3'b000, 5'd3, 7'b0010011));
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
    prog.push_back(enc_s(12'h600, 5'd3, 5'd0));
    prog.push_back(enc_s(12'h604, 5'd1, 5'd0));
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
    prog.push_back(enc_s(12'h608, 5'd3, 5'd0));
    prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b000));
    prog.push_back(enc_s(12'h60c, 5'd2, 5'd0));
    prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b001));
    prog.push_back(enc_s(12'h610, 5'd3, 5'd0));
    prog.push_back(enc_j(21'd8, 5'd5));
    prog.push_back(enc_s(12'h614, 5'd1, 5'd0));
    prog.push_back(enc_s(12'h618, 5'd5, 5'd0));
    prog.push_back(enc_i(12'd3, 5'd0, 3'b000, 5'd4, 7'b0010011));
    prog.push_back(enc_i(12'hfff, 5'd4, 3'b000, 5'd4, 7'b0010011));
    prog.push_back(enc_s(12'h620, 5'd4, 5'd0));
    prog.push_back(enc_b(-13'sd8, 5'd0, 5'd4, 3'b001));
    run_program("control");

    // Fetches and data accesses contending for the bus
    emit_reg_init();
    for (int k = 0; k < 40; k++) begin
      case ($urandom_range(2, 0))
        0: prog.push_back(enc_i(12'h700 + 4 * $urandom_range(15, 0), 5'd0, 3'b010,
                                $urandom_range(7, 1), 7'b0000011));
        1: prog.push_back(enc_s(12'h700 + 4 * $urandom_range(15, 0),
                                $urandom_range(7, 0), 5'd0));
        default: emit_random_alu($urandom_range(7, 1));
      endcase
    end
    run_program("contention");

    $display("Errors: %0d in %0d stores checked", chk0.error_count, chk0.store_count);
    if (chk0.error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/core_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module core_checker import core_pkg::*; (
  input wire logic    clk,
  input wire logic    reset_n,
  input wire wb_req_t wb_o,
  input wire wb_rsp_t wb_i
);

  localparam logic [`CORE_XLEN/8-1:0] SEL_ALL = '1;

  string test_name;
  word_t exp_adr [$];
  word_t exp_dat [$];
  int    error_count;
  int    store_count;
  int    store_idx;
  logic  first_fetch;

  initial begin
    test_name   = "none";
    error_count = 0;
    store_count = 0;
    store_idx   = 0;
    first_fetch = 1'b1;
  end

  task automatic start_test(input string name);
    test_name = name;
    store_idx = 0;
    exp_adr.delete();
    exp_dat.delete();
  endtask

  task automatic expect_store(input word_t adr, input word_t dat);
    exp_adr.push_back(adr);
    exp_dat.push_back(dat);
  endtask

  // Whatever is left in the queue never reached the bus
  task automatic finish_test();
    if (exp_adr.size() != 0) begin
      $display("Test %s: %0d expected stores never appeared on the bus",
               test_name, exp_adr.size());
      error_count++;
    end
  endtask

  // --------------------------------------------------
  // Bus monitor
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!reset_n) begin
      first_fetch = 1'b1;
      if (wb_o.cyc || wb_o.stb) begin
        $display("Test %s: a bus cycle was started while in reset", test_name);
        error_count++;
      end
    end else begin
      // First cycle after reset must fetch from the reset address
      if (first_fetch) begin
        first_fetch = 1'b0;
        if (!(wb_o.cyc && wb_o.stb)) begin
          $display("Test %s: no fetch was started in the first cycle after reset",
                   test_name);
          error_count++;
        end else if (wb_o.we || wb_o.adr != `CORE_RESET_ADDR) begin
          $display("Error: test %s first fetch expected %h actual %h",
                   test_name, `CORE_RESET_ADDR, wb_o.adr);
          error_count++;
        end
      end
      if (wb_o.cyc && wb_o.stb) begin
        if (wb_o.sel != SEL_ALL) begin
          $display("Error: test %s byte select expected %h actual %h",
                   test_name, SEL_ALL, wb_o.sel);
          error_count++;
        end
        if (wb_o.we && wb_i.ack) begin
          store_count++;
          if (exp_adr.size() == 0) begin
            $display("Test %s: extra store of %h to address %h", test_name,
                     wb_o.dat, wb_o.adr);
            error_count++;
          end else begin
            if (wb_o.adr != exp_adr[0] || wb_o.dat != exp_dat[0]) begin
              $display("Error: test %s store %0d expected %h @ %h actual %h @ %h",
                       test_name, store_idx, exp_dat[0], exp_adr[0],
                       wb_o.dat, wb_o.adr);
              error_count++;
            end
            void'(exp_adr.pop_front());
            void'(exp_dat.pop_front());
          end
          store_idx++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
  input  wire logic    clk,
  input  wire logic    reset_n,
  output wb_req_t      wb_o,
  input  wire wb_rsp_t wb_i
);

  // --------------------------------------------------
  // Fetch to execute
  // --------------------------------------------------
  logic     if_instr_valid;
  word_t    if_instr;
  word_t    if_instr_pc;
  logic     exe_instr_take;
  logic     exe_redirect_v;
  word_t    exe_redirect_pc;

  // Register file
  reg_adr_t exe_rs1_adr;
  reg_adr_t exe_rs2_adr;
  word_t    rf_rs1_data;
  word_t    rf_rs2_data;
  logic     exe_rd_we;
  reg_adr_t exe_rd_adr;
  word_t    exe_rd_data;

  // Execute to load/store
  logic     exe_mem_start;
  logic     exe_mem_we;
  word_t    exe_mem_adr;
  word_t    exe_mem_wdata;
  logic     lsu_done;
  word_t    lsu_rdata;

  // Requests towards the arbiter
  mem_req_t if_fetch_req;
  mem_rsp_t arb_fetch_rsp;
  mem_req_t lsu_data_req;
  mem_rsp_t arb_data_rsp;

  ifetch u_ifetch (
    .clk           (clk),
    .reset_n       (reset_n),
    .redirect_v_i  (exe_redirect_v),
    .redirect_pc_i (exe_redirect_pc),
    .instr_take_i  (exe_instr_take),
    .instr_valid_o (if_instr_valid),
    .instr_o       (if_instr),
    .instr_pc_o    (if_instr_pc),
    .fetch_req_o   (if_fetch_req),
    .fetch_rsp_i   (arb_fetch_rsp)
  );

  exec_unit u_exec_unit (
    .clk           (clk),
    .reset_n       (reset_n),
    .instr_valid_i (if_instr_valid),
    .instr_i       (if_instr),
    .instr_pc_i    (if_instr_pc),
    .instr_take_o  (exe_instr_take),
    .redirect_v_o  (exe_redirect_v),
    .redirect_pc_o (exe_redirect_pc),
    .rs1_adr_o     (exe_rs1_adr),
    .rs2_adr_o     (exe_rs2_adr),
    .rs1_data_i    (rf_rs1_data),
    .rs2_data_i    (rf_rs2_data),
    .rd_we_o       (exe_rd_we),
    .rd_adr_o      (exe_rd_adr),
    .rd_data_o     (exe_rd_data),
    .mem_start_o   (exe_mem_start),
    .mem_we_o      (exe_mem_we),
    .mem_adr_o     (exe_mem_adr),
    .mem_wdata_o   (exe_mem_wdata),
    .mem_done_i    (lsu_done),
    .mem_rdata_i   (lsu_rdata)
  );

  regfile u_regfile (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_adr_i  (exe_rs1_adr),
    .rs2_adr_i  (exe_rs2_adr),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data),
    .we_i       (exe_rd_we),
    .wr_adr_i   (exe_rd_adr),
    .wr_data_i  (exe_rd_data)
  );

  lsu u_lsu (
    .clk        (clk),
    .reset_n    (reset_n),
    .start_i    (exe_mem_start),
    .we_i       (exe_mem_we),
    .adr_i      (exe_mem_adr),
    .wdata_i    (exe_mem_wdata),
    .done_o     (lsu_done),
    .rdata_o    (lsu_rdata),
    .data_req_o (lsu_data_req),
    .data_rsp_i (arb_data_rsp)
  );

  bus_arbiter u_bus_arbiter (
    .clk         (clk),
    .reset_n     (reset_n),
    .data_req_i  (lsu_data_req),
    .data_rsp_o  (arb_data_rsp),
    .fetch_req_i (if_fetch_req),
    .fetch_rsp_o (arb_fetch_rsp),
    .wb_o        (wb_o),
    .wb_i        (wb_i)
  );

endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter import core_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset_n,
  input  wire mem_req_t data_req_i,
  output mem_rsp_t      data_rsp_o,
  input  wire mem_req_t fetch_req_i,
  output mem_rsp_t      fetch_rsp_o,
  output wb_req_t       wb_o,
  input  wire wb_rsp_t  wb_i
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_DATA,
    ARB_FETCH
  } arb_state_e;

  arb_state_e state_q;
  arb_state_e state_d;
  logic       sel_data;
  logic       sel_fetch;

  // Fixed priority when idle with data before fetch
  always_comb begin
    if (state_q == ARB_IDLE) begin
      sel_data  = data_req_i.valid;
      sel_fetch = !data_req_i.valid && fetch_req_i.valid;
    end else begin
      sel_data  = (state_q == ARB_DATA);
      sel_fetch = (state_q == ARB_FETCH);
    end
  end

  // Owner is kept until its ack
  always_comb begin
    state_d = state_q;
    if (wb_i.ack) begin
      state_d = ARB_IDLE;
    end else if (state_q == ARB_IDLE) begin
      if (sel_data) begin
        state_d = ARB_DATA;
      end else if (sel_fetch) begin
        state_d = ARB_FETCH;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // Wishbone master side
  // --------------------------------------------------
  assign wb_o.cyc = sel_data || sel_fetch;
  assign wb_o.stb = sel_data || sel_fetch;
  assign wb_o.we  = sel_data ? data_req_i.we : (sel_fetch && fetch_req_i.we);
  assign wb_o.adr = sel_data ? data_req_i.adr : fetch_req_i.adr;
  assign wb_o.dat = sel_data ? data_req_i.wdata : fetch_req_i.wdata;
  assign wb_o.sel = '1;

  assign data_rsp_o.ack    = sel_data && wb_i.ack;
  assign data_rsp_o.rdata  = wb_i.dat;
  assign fetch_rsp_o.ack   = sel_fetch && wb_i.ack;
  assign fetch_rsp_o.rdata = wb_i.dat;

endmodule

`default_nettype wire

/* rtl/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu import core_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset_n,
  input  wire logic     start_i,
  input  wire logic     we_i,
  input  wire word_t    adr_i,
  input  wire word_t    wdata_i,
  output logic          done_o,
  output word_t         rdata_o,
  output mem_req_t      data_req_o,
  input  wire mem_rsp_t data_rsp_i
);

  logic  valid_q;
  logic  done_q;
  logic  we_q;
  word_t adr_q;
  word_t wdata_q;
  word_t rdata_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // Done follows the bus ack by one cycle
      done_q <= data_rsp_i.ack;
      if (start_i) begin
        valid_q <= 1'b1;
      end else if (data_rsp_i.ack) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      we_q    <= we_i;
      adr_q   <= adr_i;
      wdata_q <= wdata_i;
    end
    if (data_rsp_i.ack && !we_q) begin
      rdata_q <= data_rsp_i.rdata;
    end
  end

  assign data_req_o.valid = valid_q;
  assign data_req_o.we    = we_q;
  assign data_req_o.adr   = adr_q;
  assign data_req_o.wdata = wdata_q;

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module regfile import core_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset_n,
  input  wire reg_adr_t rs1_adr_i,
  input  wire reg_adr_t rs2_adr_i,
  output word_t         rs1_data_o,
  output word_t         rs2_data_o,
  input  wire logic     we_i,
  input  wire reg_adr_t wr_adr_i,
  input  wire word_t    wr_data_i
);

  word_t regs_q [`CORE_NB_REGS];

  // x0 keeps its reset value since it is never written
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `CORE_NB_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && wr_adr_i != '0) begin
      regs_q[wr_adr_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = regs_q[rs1_adr_i];
  assign rs2_data_o = regs_q[rs2_adr_i];

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit import core_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset_n,
  input  wire logic  instr_valid_i,
  input  wire word_t instr_i,
  input  wire word_t instr_pc_i,
  output logic       instr_take_o,
  output logic       redirect_v_o,
  output word_t      redirect_pc_o,
  output reg_adr_t   rs1_adr_o,
  output reg_adr_t   rs2_adr_o,
  input  wire word_t rs1_data_i,
  input  wire word_t rs2_data_i,
  output logic       rd_we_o,
  output reg_adr_t   rd_adr_o,
  output word_t      rd_data_o,
  output logic       mem_start_o,
  output logic       mem_we_o,
  output word_t      mem_adr_o,
  output word_t      mem_wdata_o,
  input  wire logic  mem_done_i,
  input  wire word_t mem_rdata_i
);

  exec_state_e state_q;
  exec_state_e state_d;
  dec_t        dec_q;
  word_t       pc_q;
  word_t       result_q;
  word_t       op_b;
  word_t       alu_res;
  logic        taken;
  logic        is_mem;

  // --------------------------------------------------
  // Decoder
  // --------------------------------------------------
  function automatic dec_t decode(word_t ins);
    dec_t       d;
    opcode_e    opc;
    logic [2:0] f3;
    f3       = ins[14:12];
    opc      = opcode_e'(ins[6:0]);
    d        = '0;
    d.alu_op = ALU_ADD;
    d.rd     = ins[11:7];
    d.rs1    = ins[19:15];
    d.rs2    = ins[24:20];
    d.imm    = {{20{ins[31]}}, ins[31:20]};
    case (opc)
      OPC_OP: begin
        // Only funct7 0000000, or 0100000 for SUB
        if (!ins[31] && ins[29:25] == 5'd0 && (!ins[30] || f3 == 3'b000)) begin
          d.write_rd = 1'b1;
          case (f3)
            3'b000:  d.alu_op = ins[30] ? ALU_SUB : ALU_ADD;
            3'b010:  d.alu_op = ALU_SLT;
            3'b100:  d.alu_op = ALU_XOR;
            3'b110:  d.alu_op = ALU_OR;
            3'b111:  d.alu_op = ALU_AND;
            default: d.write_rd = 1'b0;
          endcase
        end
      end
      OPC_OP_IMM: begin
        d.use_imm  = 1'b1;
        d.write_rd = 1'b1;
        case (f3)
          3'b000:  d.alu_op = ALU_ADD;
          3'b010:  d.alu_op = ALU_SLT;
          3'b100:  d.alu_op = ALU_XOR;
          3'b110:  d.alu_op = ALU_OR;
          3'b111:  d.alu_op = ALU_AND;
          default: d.write_rd = 1'b0;
        endcase
      end
      OPC_LUI: begin
        d.alu_op   = ALU_PASS_B;
        d.use_imm  = 1'b1;
        d.write_rd = 1'b1;
        d.imm      = {ins[31:12], 12'b0};
      end
      OPC_LOAD: begin
        d.use_imm  = 1'b1;
        d.load     = (f3 == 3'b010);
        d.write_rd = (f3 == 3'b010);
      end
      OPC_STORE: begin
        d.use_imm = 1'b1;
        d.store   = (f3 == 3'b010);
        d.imm     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      end
      OPC_BRANCH: begin
        d.beq = (f3 == 3'b000);
        d.bne = (f3 == 3'b001);
        d.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      OPC_JAL: begin
        d.jump     = 1'b1;
        d.write_rd = 1'b1;
        d.imm      = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: ;
    endcase
    return d;
  endfunction

  // --------------------------------------------------
  // ALU and branch resolution
  // --------------------------------------------------
  assign op_b = dec_q.use_imm ? dec_q.imm : rs2_data_i;

  always_comb begin
    case (dec_q.alu_op)
      ALU_SUB:    alu_res = rs1_data_i - op_b;
      ALU_SLT:    alu_res = word_t'($signed(rs1_data_i) < $signed(op_b));
      ALU_XOR:    alu_res = rs1_data_i ^ op_b;
      ALU_OR:     alu_res = rs1_data_i | op_b;
      ALU_AND:    alu_res = rs1_data_i & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = rs1_data_i + op_b;
    endcase
  end

  assign taken  = (dec_q.beq && rs1_data_i == rs2_data_i) ||
                  (dec_q.bne && rs1_data_i != rs2_data_i) || dec_q.jump;
  assign is_mem = dec_q.load || dec_q.store;

  // --------------------------------------------------
  // Sequencer
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_WAIT_INSTR: if (instr_valid_i) state_d = ST_EXECUTE;
      ST_EXECUTE:    state_d = is_mem ? ST_MEM_WAIT : ST_WRITEBACK;
      ST_MEM_WAIT:   if (mem_done_i) state_d = ST_WRITEBACK;
      default:       state_d = ST_WAIT_INSTR;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ST_WAIT_INSTR;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_take_o) begin
      dec_q <= decode(instr_i);
      pc_q  <= instr_pc_i;
    end
    // JAL links to the next sequential address
    if (state_q == ST_EXECUTE) begin
      result_q <= dec_q.jump ? pc_q + word_t'(4) : alu_res;
    end
  end

  assign instr_take_o  = (state_q == ST_WAIT_INSTR) && instr_valid_i;
  assign redirect_v_o  = (state_q == ST_EXECUTE) && taken;
  assign redirect_pc_o = pc_q + dec_q.imm;

  assign rs1_adr_o = dec_q.rs1;
  assign rs2_adr_o = dec_q.rs2;

  assign rd_we_o   = (state_q == ST_WRITEBACK) && dec_q.write_rd;
  assign rd_adr_o  = dec_q.rd;
  assign rd_data_o = dec_q.load ? mem_rdata_i : result_q;

  assign mem_start_o = (state_q == ST_EXECUTE) && is_mem;
  assign mem_we_o    = dec_q.store;
  assign mem_adr_o   = alu_res;
  assign mem_wdata_o = rs2_data_i;

endmodule

`default_nettype wire

/* rtl/ifetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module ifetch import core_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset_n,
  input  wire logic     redirect_v_i,
  input  wire word_t    redirect_pc_i,
  input  wire logic     instr_take_i,
  output logic          instr_valid_o,
  output word_t         instr_o,
  output word_t         instr_pc_o,
  output mem_req_t      fetch_req_o,
  input  wire mem_rsp_t fetch_rsp_i
);

  word_t pc_q;
  word_t req_adr_q;
  logic  busy_q;
  logic  gap_q;
  logic  discard_q;
  logic  buf_valid_q;
  word_t buf_instr_q;
  word_t buf_pc_q;
  logic  room;
  logic  fetch_start;
  logic  fetch_ack;

  // Buffer has room when empty or emptied this cycle
  assign room        = !buf_valid_q || instr_take_i;
  // No request while reset is held
  assign fetch_start = reset_n && !busy_q && !gap_q && room && !redirect_v_i;
  assign fetch_ack   = fetch_rsp_i.ack;

  // Address is frozen once the request is out
  assign fetch_req_o.valid = busy_q || fetch_start;
  assign fetch_req_o.we    = 1'b0;
  assign fetch_req_o.adr   = busy_q ? req_adr_q : pc_q;
  assign fetch_req_o.wdata = '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc_q        <= `CORE_RESET_ADDR;
      busy_q      <= 1'b0;
      gap_q       <= 1'b0;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      gap_q <= fetch_ack;
      if (fetch_ack) begin
        busy_q <= 1'b0;
      end else if (fetch_start) begin
        busy_q <= 1'b1;
      end
      if (redirect_v_i) begin
        pc_q        <= redirect_pc_i;
        buf_valid_q <= 1'b0;
        // A fetch still on the bus belongs to the old path
        discard_q   <= busy_q && !fetch_ack;
      end else if (fetch_ack) begin
        discard_q <= 1'b0;
        if (!discard_q) begin
          buf_valid_q <= 1'b1;
          pc_q        <= pc_q + word_t'(4);
        end
      end else if (instr_take_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      req_adr_q <= pc_q;
    end
    if (fetch_ack && !discard_q && !redirect_v_i) begin
      buf_instr_q <= fetch_rsp_i.rdata;
      buf_pc_q    <= pc_q;
    end
  end

  assign instr_valid_o = buf_valid_q;
  assign instr_o       = buf_instr_q;
  assign instr_pc_o    = buf_pc_q;

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

`include "core_config.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]      word_t;
  typedef logic [`CORE_REG_ADR_W-1:0] reg_adr_t;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_WAIT_INSTR,
    ST_EXECUTE,
    ST_MEM_WAIT,
    ST_WRITEBACK
  } exec_state_e;

  // One decoded instruction
  typedef struct packed {
    alu_op_e  alu_op;
    reg_adr_t rd;
    reg_adr_t rs1;
    reg_adr_t rs2;
    word_t    imm;
    logic     use_imm;
    logic     write_rd;
    logic     load;
    logic     store;
    logic     beq;
    logic     bne;
    logic     jump;
  } dec_t;

  // Unit to arbiter request and its answer
  typedef struct packed {
    logic  valid;
    logic  we;
    word_t adr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ack;
    word_t rdata;
  } mem_rsp_t;

  // Wishbone classic master outputs and slave answer
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    word_t                    adr;
    word_t                    dat;
    logic [`CORE_XLEN/8-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// --------------------------------------------------
// Core configuration
// --------------------------------------------------

// Data and address width
`define CORE_XLEN 32

// Number of integer registers
`define CORE_NB_REGS 32

// Register index width
`define CORE_REG_ADR_W 5

// First fetch address after reset
`define CORE_RESET_ADDR 32'h0000_0000

`endif
